// ==== dv/mips_cases.txt ====
// Program word count, then the program words from address 0, four per line.
// Writeback count, then one writeback per line: pc, register number, data.
00000014
24010005 2402fffd 00221821 00612023
00812824 00a23025 0041382a 0022402a
24090040 ad260004 8d2a0004 01415821
11630002 240c0001 240d0002 10220001
240e0007 25cf0100 3c101234 01e78021
0000000e
00000000 01 00000005
00000004 02 fffffffd
00000008 03 00000002
0000000c 04 fffffffd
00000010 05 00000005
00000014 06 fffffffd
00000018 07 00000001
0000001c 08 00000000
00000020 09 00000040
00000028 0a fffffffd
0000002c 0b 00000002
00000040 0e 00000007
00000044 0f 00000107
0000004c 10 00000108

// ==== flist.f ====
+incdir+common
common/mips_pkg.sv
datapath/regfile.sv
datapath/alu.sv
datapath/datapath.sv
rtl/controller.sv
rtl/hazard.sv
rtl/mips.sv
dv/tb_mips.sv

// ==== dv/tb_mips.sv ====
`default_nettype none
`include "mips_defines.svh"

module tb_mips;

    localparam int XLEN       = `MIPS_XLEN;
    localparam int CASE_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int DRAIN      = 10;

    logic            clk;
    logic            reset;
    logic            stall_from_cache;
    logic            inst_sram_en;
    logic [3:0]      inst_sram_wen;
    logic [XLEN-1:0] inst_sram_addr;
    logic [XLEN-1:0] inst_sram_wdata;
    logic [XLEN-1:0] inst_sram_rdata;
    logic            data_sram_en;
    logic [3:0]      data_sram_wen;
    logic [XLEN-1:0] data_sram_addr;
    logic [XLEN-1:0] data_sram_wdata;
    logic [XLEN-1:0] data_sram_rdata;
    logic [XLEN-1:0] debug_wb_pc;
    logic [3:0]      debug_wb_rf_wen;
    logic [4:0]      debug_wb_rf_wnum;
    logic [XLEN-1:0] debug_wb_rf_wdata;

    // Program words and the expected writeback trace.
    logic [XLEN-1:0] cases [0:CASE_WORDS-1];
    logic [XLEN-1:0] dmem [0:DMEM_WORDS-1];
    int              prog_len;
    int              wb_count;
    int              wb_base;
    int              wb_idx = 0;
    int              cycle;
    int              limit;
    int              drain;
    int unsigned     seed_val;

    mips UUT (
        .clk               (clk),
        .reset             (reset),
        .stall_from_cache  (stall_from_cache),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
                                $time, name, got, expected));
        end
    endtask

    task automatic expect_regnum(input string name, input logic [4:0] got,
                                 input logic [4:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("MISMATCH time=%0t %s got=%0d expected=%0d",
                                $time, name, got, expected));
        end
    endtask

    task automatic idle_after_reset();
        compare_word("inst_sram_addr", inst_sram_addr, `MIPS_RESET_PC);
        if (inst_sram_en !== 1'b1) begin
            abort_run("Instruction fetch is not enabled once reset is released");
        end
        if (debug_wb_rf_wen !== 4'b0) begin
            abort_run($sformatf("MISMATCH time=%0t debug_wb_rf_wen got=%b expected=0000",
                                $time, debug_wb_rf_wen));
        end
        if ({data_sram_en, data_sram_wen} !== 5'b0) begin
            abort_run($sformatf("MISMATCH time=%0t data_sram_en/wen got=%b/%b expected=0/0000",
                                $time, data_sram_en, data_sram_wen));
        end
    endtask

    // Addresses past the program read as NOP.
    function automatic logic [XLEN-1:0] instr_at(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] word;
        word = '0;
        if (addr[XLEN-1:2] < prog_len) begin
            word = cases[1 + addr[XLEN-1:2]];
        end
        return word;
    endfunction

    // The instruction port is read only.
    always @(posedge clk) begin
        if (!reset) begin
            if (inst_sram_wen !== 4'b0) begin
                abort_run($sformatf("MISMATCH time=%0t inst_sram_wen got=%b expected=0000",
                                    $time, inst_sram_wen));
            end
            compare_word("inst_sram_wdata", inst_sram_wdata, '0);
        end
        if (inst_sram_en) begin
            inst_sram_rdata <= instr_at(inst_sram_addr);
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            if (data_sram_addr >= XLEN'(DMEM_WORDS * 4)) begin
                abort_run($sformatf("Data access at %h is outside the modeled memory",
                                    data_sram_addr));
            end else if (data_sram_wen != 4'b0) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_sram_wen[b]) begin
                        dmem[data_sram_addr[9:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                    end
                end
            end else begin
                data_sram_rdata <= dmem[data_sram_addr[9:2]];
            end
        end
    end

    // Writeback trace is sampled at the edge that commits the write.
    always @(posedge clk) begin
        int base;
        if (!reset && (debug_wb_rf_wen !== 4'b0)) begin
            base = wb_base + 3 * wb_idx;
            if (debug_wb_rf_wen !== 4'hf) begin
                abort_run($sformatf("Write enable %b is neither all zeros nor all ones",
                                    debug_wb_rf_wen));
            end else if (wb_idx >= wb_count) begin
                abort_run($sformatf("Unexpected writeback at time %0t after the trace ended",
                                    $time));
            end else begin
                compare_word("debug_wb_pc", debug_wb_pc, cases[base]);
                expect_regnum("debug_wb_rf_wnum", debug_wb_rf_wnum, cases[base+1][4:0]);
                compare_word("debug_wb_rf_wdata", debug_wb_rf_wdata, cases[base+2]);
                wb_idx = wb_idx + 1;
            end
        end
    end

    initial begin
        seed_val = $urandom(33);
        reset            = 1'b1;
        stall_from_cache = 1'b0;
        inst_sram_rdata  = '0;
        data_sram_rdata  = '0;
        $readmemh("dv/mips_cases.txt", cases);
        prog_len = cases[0];
        wb_count = cases[prog_len + 1];
        wb_base  = prog_len + 2;
        limit    = 8 * wb_count + 4 * prog_len + 100;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hdada_0000 ^ XLEN'(i * 4);
        end

        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        idle_after_reset();

        // Random cache back-pressure on about a quarter of the cycles.
        cycle = 0;
        drain = 0;
        while (drain < DRAIN) begin
            stall_from_cache = (($urandom % 4) == 0);
            @(negedge clk);
            cycle = cycle + 1;
            if (wb_idx == wb_count) begin
                drain = drain + 1;
            end else if (cycle >= limit) begin
                abort_run($sformatf("Timeout, writeback trace did not finish after %0d cycles",
                                    cycle));
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/mips.sv ====
`default_nettype none
`include "mips_defines.svh"

module mips import mips_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  stall_from_cache,
    output logic                       inst_sram_en,
    output logic [3:0]                 inst_sram_wen,
    output logic [`MIPS_XLEN-1:0]      inst_sram_addr,
    output logic [`MIPS_XLEN-1:0]      inst_sram_wdata,
    input  wire logic [`MIPS_XLEN-1:0] inst_sram_rdata,
    output logic                       data_sram_en,
    output logic [3:0]                 data_sram_wen,
    output logic [`MIPS_XLEN-1:0]      data_sram_addr,
    output logic [`MIPS_XLEN-1:0]      data_sram_wdata,
    input  wire logic [`MIPS_XLEN-1:0] data_sram_rdata,
    output logic [`MIPS_XLEN-1:0]      debug_wb_pc,
    output logic [3:0]                 debug_wb_rf_wen,
    output logic [4:0]                 debug_wb_rf_wnum,
    output logic [`MIPS_XLEN-1:0]      debug_wb_rf_wdata
);

    logic [`MIPS_XLEN-1:0] instr_d;
    main_ctrl_t            main_ctrl;
    alu_op_e               alu_op;
    hazard_data_t          hazard_data;
    hazard_ctrl_t          hazard_ctrl;

    datapath u_datapath (
        .clk               (clk),
        .reset             (reset),
        .stall_from_cache  (stall_from_cache),
        .instr_d           (instr_d),
        .main_ctrl         (main_ctrl),
        .alu_op            (alu_op),
        .hazard_data       (hazard_data),
        .hazard_ctrl       (hazard_ctrl),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    controller u_controller (
        .instr     (instr_d),
        .main_ctrl (main_ctrl),
        .alu_op    (alu_op)
    );

    hazard u_hazard (
        .hazard_data (hazard_data),
        .hazard_ctrl (hazard_ctrl)
    );

endmodule

`default_nettype wire

// ==== rtl/hazard.sv ====
`default_nettype none

module hazard import mips_pkg::*; (
    input  wire hazard_data_t hazard_data,
    output hazard_ctrl_t      hazard_ctrl
);

    logic load_use;

    // MEM has priority since it holds the younger result.
    function automatic logic [1:0] forward_sel(input logic [4:0] src, input hazard_data_t hd);
        logic [1:0] sel;
        sel = 2'd0;
        if (src != '0) begin
            if (hd.reg_write_m && (src == hd.write_reg_m)) begin
                sel = 2'd2;
            end else if (hd.reg_write_w && (src == hd.write_reg_w)) begin
                sel = 2'd1;
            end
        end
        return sel;
    endfunction

    // Load in EX feeding the instruction in decode.
    assign load_use = hazard_data.mem_to_reg_e && (hazard_data.rt_e != '0) &&
                      ((hazard_data.rs_d == hazard_data.rt_e) ||
                       (hazard_data.rt_d == hazard_data.rt_e));

    always_comb begin
        hazard_ctrl.stall_f     = load_use;
        hazard_ctrl.stall_d     = load_use;
        hazard_ctrl.flush_d     = hazard_data.branch_taken_e;
        hazard_ctrl.flush_e     = load_use | hazard_data.branch_taken_e;
        hazard_ctrl.forward_a_e = forward_sel(hazard_data.rs_e, hazard_data);
        hazard_ctrl.forward_b_e = forward_sel(hazard_data.rt_e, hazard_data);
    end

endmodule

`default_nettype wire

// ==== rtl/controller.sv ====
`default_nettype none
`include "mips_defines.svh"

module controller import mips_pkg::*; (
    input  wire logic [`MIPS_XLEN-1:0] instr,
    output main_ctrl_t                 main_ctrl,
    output alu_op_e                    alu_op
);

    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;

    opcode_e    opcode;
    logic [5:0] funct;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = instr[5:0];

    always_comb begin
        main_ctrl = '0;
        alu_op    = ALU_ADD;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FUNCT_SUBU: alu_op = ALU_SUB;
                    FUNCT_AND:  alu_op = ALU_AND;
                    FUNCT_OR:   alu_op = ALU_OR;
                    FUNCT_SLT:  alu_op = ALU_SLT;
                    default:    alu_op = ALU_ADD;
                endcase
                // Unlisted funct codes stay a no-op.
                if (funct inside {FUNCT_ADDU, FUNCT_SUBU, FUNCT_AND, FUNCT_OR, FUNCT_SLT}) begin
                    main_ctrl.reg_write = 1'b1;
                    main_ctrl.reg_dst   = 1'b1;
                end
            end
            OP_ADDIU: begin
                main_ctrl.reg_write = 1'b1;
                main_ctrl.alu_src   = 1'b1;
            end
            OP_LW: begin
                main_ctrl.reg_write  = 1'b1;
                main_ctrl.mem_to_reg = 1'b1;
                main_ctrl.alu_src    = 1'b1;
            end
            OP_SW: begin
                main_ctrl.mem_write = 1'b1;
                main_ctrl.alu_src   = 1'b1;
            end
            OP_BEQ: begin
                main_ctrl.branch = 1'b1;
                alu_op           = ALU_SUB;
            end
            default: main_ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== datapath/datapath.sv ====
`default_nettype none
`include "mips_defines.svh"

module datapath import mips_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  stall_from_cache,
    output logic [`MIPS_XLEN-1:0]      instr_d,
    input  wire main_ctrl_t            main_ctrl,
    input  wire alu_op_e               alu_op,
    output hazard_data_t               hazard_data,
    input  wire hazard_ctrl_t          hazard_ctrl,
    output logic                       inst_sram_en,
    output logic [3:0]                 inst_sram_wen,
    output logic [`MIPS_XLEN-1:0]      inst_sram_addr,
    output logic [`MIPS_XLEN-1:0]      inst_sram_wdata,
    input  wire logic [`MIPS_XLEN-1:0] inst_sram_rdata,
    output logic                       data_sram_en,
    output logic [3:0]                 data_sram_wen,
    output logic [`MIPS_XLEN-1:0]      data_sram_addr,
    output logic [`MIPS_XLEN-1:0]      data_sram_wdata,
    input  wire logic [`MIPS_XLEN-1:0] data_sram_rdata,
    output logic [`MIPS_XLEN-1:0]      debug_wb_pc,
    output logic [3:0]                 debug_wb_rf_wen,
    output logic [4:0]                 debug_wb_rf_wnum,
    output logic [`MIPS_XLEN-1:0]      debug_wb_rf_wdata
);

    localparam int XLEN = `MIPS_XLEN;

    logic            run_q, adv, adv_f, adv_d;
    logic [XLEN-1:0] pc_f, pc_d, instr_q, rd1_d, rd2_d, imm_d;
    logic            valid_d, hold_d;
    main_ctrl_t      ctrl_e, ctrl_m, ctrl_w;
    alu_op_e         op_e;
    logic [XLEN-1:0] pc_e, rd1_e, rd2_e, imm_e, src_a_e, src_b_e, wdata_e, alu_y_e, target_e;
    logic [4:0]      rs_e, rt_e, rd_e, write_reg_e, write_reg_m, write_reg_w;
    logic            zero_e, branch_taken_e;
    logic [XLEN-1:0] pc_m, alu_out_m, wdata_m;
    logic [XLEN-1:0] pc_w, alu_out_w, load_q, load_w, result_w;
    logic            hold_w, reg_we_w;

    // Cache back-pressure freezes every stage.
    assign adv   = ~stall_from_cache;
    assign adv_f = adv & run_q & ~hazard_ctrl.stall_f;
    assign adv_d = adv & ~hazard_ctrl.stall_d;

    // Fetch. The word for pc_f arrives one cycle later as the decode instruction.
    always_ff @(posedge clk) begin
        if (reset) begin
            run_q <= 1'b0;
            pc_f  <= `MIPS_RESET_PC;
        end else begin
            run_q <= 1'b1;
            if (adv_f) begin
                pc_f <= branch_taken_e ? target_e : pc_f + XLEN'(4);
            end
        end
    end

    assign inst_sram_en    = run_q;
    assign inst_sram_addr  = pc_f;
    assign inst_sram_wen   = 4'b0;
    assign inst_sram_wdata = '0;

    // Decode. A held stage replays its saved word and a flushed one decodes as zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_d <= 1'b0;
            hold_d  <= 1'b0;
        end else begin
            hold_d <= ~adv_d;
            if (adv_d) begin
                valid_d <= run_q & ~hazard_ctrl.flush_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= instr_d;
        if (adv_d) begin
            pc_d <= pc_f;
        end
    end

    assign instr_d = hold_d ? instr_q : (valid_d ? inst_sram_rdata : '0);
    assign imm_d   = {{(XLEN-16){instr_d[15]}}, instr_d[15:0]};

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .we    (reg_we_w),
        .ra1   (instr_d[25:21]),
        .ra2   (instr_d[20:16]),
        .wa    (write_reg_w),
        .wd    (result_w),
        .rd1   (rd1_d),
        .rd2   (rd2_d)
    );

    // D/E register.
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_e <= '0;
        end else if (adv) begin
            ctrl_e <= hazard_ctrl.flush_e ? '0 : main_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            op_e  <= alu_op;
            pc_e  <= pc_d;
            rd1_e <= rd1_d;
            rd2_e <= rd2_d;
            imm_e <= imm_d;
            rs_e  <= instr_d[25:21];
            rt_e  <= instr_d[20:16];
            rd_e  <= instr_d[15:11];
        end
    end

    // Execute.
    assign src_a_e = (hazard_ctrl.forward_a_e == 2'd2) ? alu_out_m :
                     (hazard_ctrl.forward_a_e == 2'd1) ? result_w : rd1_e;
    assign wdata_e = (hazard_ctrl.forward_b_e == 2'd2) ? alu_out_m :
                     (hazard_ctrl.forward_b_e == 2'd1) ? result_w : rd2_e;
    assign src_b_e = ctrl_e.alu_src ? imm_e : wdata_e;

    alu u_alu (
        .a    (src_a_e),
        .b    (src_b_e),
        .op   (op_e),
        .y    (alu_y_e),
        .zero (zero_e)
    );

    assign write_reg_e    = ctrl_e.reg_dst ? rd_e : rt_e;
    assign target_e       = pc_e + XLEN'(4) + {imm_e[XLEN-3:0], 2'b00};
    assign branch_taken_e = ctrl_e.branch & zero_e;

    // E/M register.
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_m <= '0;
        end else if (adv) begin
            ctrl_m <= ctrl_e;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            pc_m        <= pc_e;
            alu_out_m   <= alu_y_e;
            wdata_m     <= wdata_e;
            write_reg_m <= write_reg_e;
        end
    end

    assign data_sram_en    = ctrl_m.mem_to_reg | ctrl_m.mem_write;
    assign data_sram_wen   = {4{ctrl_m.mem_write}};
    assign data_sram_addr  = alu_out_m;
    assign data_sram_wdata = wdata_m;

    // M/W register.
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_w <= '0;
            hold_w <= 1'b0;
        end else begin
            hold_w <= stall_from_cache;
            if (adv) begin
                ctrl_w <= ctrl_m;
            end
        end
    end

    always_ff @(posedge clk) begin
        load_q <= load_w;
        if (adv) begin
            pc_w        <= pc_m;
            alu_out_w   <= alu_out_m;
            write_reg_w <= write_reg_m;
        end
    end

    // Load data is on the bus for one cycle only and is kept while WB is frozen.
    assign load_w   = hold_w ? load_q : data_sram_rdata;
    assign result_w = ctrl_w.mem_to_reg ? load_w : alu_out_w;
    assign reg_we_w = ctrl_w.reg_write & adv;

    assign debug_wb_pc       = pc_w;
    assign debug_wb_rf_wen   = {4{reg_we_w}};
    assign debug_wb_rf_wnum  = write_reg_w;
    assign debug_wb_rf_wdata = result_w;

    always_comb begin
        hazard_data.rs_d           = instr_d[25:21];
        hazard_data.rt_d           = instr_d[20:16];
        hazard_data.rs_e           = rs_e;
        hazard_data.rt_e           = rt_e;
        hazard_data.write_reg_m    = write_reg_m;
        hazard_data.write_reg_w    = write_reg_w;
        hazard_data.reg_write_m    = ctrl_m.reg_write;
        hazard_data.reg_write_w    = ctrl_w.reg_write;
        hazard_data.mem_to_reg_e   = ctrl_e.mem_to_reg;
        hazard_data.branch_taken_e = branch_taken_e;
    end

    // A write mask needs the enable and never comes with a load.
    a_wen_needs_en: assert property (@(posedge clk) disable iff (reset)
        (data_sram_wen != 4'b0) |-> (data_sram_en && !ctrl_m.mem_to_reg));

    a_forward_legal: assert property (@(posedge clk) disable iff (reset)
        (hazard_ctrl.forward_a_e != 2'd3) && (hazard_ctrl.forward_b_e != 2'd3));

endmodule

`default_nettype wire

// ==== datapath/alu.sv ====
`default_nettype none
`include "mips_defines.svh"

module alu import mips_pkg::*; (
    input  wire logic [`MIPS_XLEN-1:0] a,
    input  wire logic [`MIPS_XLEN-1:0] b,
    input  wire alu_op_e               op,
    output logic [`MIPS_XLEN-1:0]      y,
    output logic                       zero
);

    logic lt;

    // Signed compare for SLT.
    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {{(`MIPS_XLEN-1){1'b0}}, lt};
            default: y = '0;
        endcase
    end

    // BEQ uses SUB and tests this flag.
    assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== datapath/regfile.sv ====
`default_nettype none
`include "mips_defines.svh"

module regfile (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  we,
    input  wire logic [4:0]            ra1,
    input  wire logic [4:0]            ra2,
    input  wire logic [4:0]            wa,
    input  wire logic [`MIPS_XLEN-1:0] wd,
    output logic [`MIPS_XLEN-1:0]      rd1,
    output logic [`MIPS_XLEN-1:0]      rd2
);

    // No storage for register 0.
    logic [`MIPS_XLEN-1:0] regs [1:`MIPS_NREGS-1];

    function automatic logic [`MIPS_XLEN-1:0] read_port(input logic [4:0] ra);
        logic [`MIPS_XLEN-1:0] val;
        if (ra == '0) begin
            val = '0;
        end else if (we && (ra == wa)) begin
            val = wd;
        end else begin
            val = regs[ra];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

    // A write to register 0 leaves every stored register untouched.
    a_zero_reg_kept: assert property (@(posedge clk) disable iff (reset)
        (we && (wa == '0)) ##1 (!we && $stable(ra1)) |-> $stable(rd1));

endmodule

`default_nettype wire

// ==== common/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // Primary opcode field in instr[31:26].
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // All zero means the instruction has no effect.
    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
        logic mem_write;
        logic alu_src;
        logic reg_dst;
        logic branch;
    } main_ctrl_t;

    typedef struct packed {
        logic [4:0] rs_d;
        logic [4:0] rt_d;
        logic [4:0] rs_e;
        logic [4:0] rt_e;
        logic [4:0] write_reg_m;
        logic [4:0] write_reg_w;
        logic       reg_write_m;
        logic       reg_write_w;
        logic       mem_to_reg_e;
        logic       branch_taken_e;
    } hazard_data_t;

    // Forward select 0 is the register file, 1 the WB result and 2 the MEM ALU result.
    typedef struct packed {
        logic       stall_f;
        logic       stall_d;
        logic       flush_d;
        logic       flush_e;
        logic [1:0] forward_a_e;
        logic [1:0] forward_b_e;
    } hazard_ctrl_t;

endpackage

`default_nettype wire

// ==== common/mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Address of the first instruction fetched after reset.
`define MIPS_RESET_PC 32'h0000_0000

// Width of data words, addresses and the PC.
`define MIPS_XLEN 32

// Architectural register count. Register 0 reads as zero.
`define MIPS_NREGS 32

`endif
